//--- decoder_comparator.sv
`timescale 1ns/1ns

module decoder_comparator
(
    input  logic                                   i_clock,
    input  logic                                   i_reset,
    input  logic                                   i_enable,
    input  logic [pcs_rx_pkg::LEN_CODED_BLOCK-1:0] i_rx_coded,
    output logic [pcs_rx_pkg::LEN_RX_DATA-1:0]     o_rx_data,
    output logic [pcs_rx_pkg::LEN_RX_CTRL-1:0]     o_rx_ctrl,
    output logic [3:0]                             o_r_type,
    output logic                                   o_valid
);
    import pcs_rx_pkg::*;

    logic [LEN_CODED_BLOCK-1:0] rx_coded;
    logic                       valid_q;
    logic [1:0]                 sh;
    rx_block_u                  blk;
    logic                       ctrl_sh;
    logic                       data_sh;

    logic                       is_t;
    logic [2:0]                 t_pos;   // lane holding /T/
    logic [0:7]                 char_ok; // char is idle or error
    logic [0:7][7:0]            cgmii_chr;
    logic [0:7][7:0]            t_data;
    logic                       trail_ok;

    logic                       type_d;
    logic                       type_s;
    logic                       type_idle;
    logic                       type_q;
    logic                       type_fsig;
    logic                       type_c;
    logic                       type_term;
    logic                       os_zero;
    logic [3:0]                 ocode;

    // input register
    always_ff @(posedge i_clock)
    begin
        if (i_enable)
            rx_coded <= i_rx_coded;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            valid_q <= 1'b0;
        else
            valid_q <= i_enable;
    end

    assign sh      = rx_coded[LEN_CODED_BLOCK-1 -: 2];
    assign blk     = rx_coded[LEN_RX_DATA-1:0];
    assign ctrl_sh = (sh == CTRL_SH);
    assign data_sh = (sh == DATA_SH);

    // which lane the terminate sits in
    always_comb
    begin
        is_t  = 1'b1;
        t_pos = 3'd0;
        case (blk.ctl.btype)
            BTYPE_T0: t_pos = 3'd0;
            BTYPE_T1: t_pos = 3'd1;
            BTYPE_T2: t_pos = 3'd2;
            BTYPE_T3: t_pos = 3'd3;
            BTYPE_T4: t_pos = 3'd4;
            BTYPE_T5: t_pos = 3'd5;
            BTYPE_T6: t_pos = 3'd6;
            BTYPE_T7: t_pos = 3'd7;
            default:  is_t  = 1'b0;
        endcase
    end

    // pcs char to cgmii char, plus trailing char check
    always_comb
    begin
        trail_ok = 1'b1;
        for (int k = 0; k < 8; k++)
        begin
            char_ok[k]   = (blk.ctl.chr[k] == PCS_IDLE) || (blk.ctl.chr[k] == PCS_ERROR);
            cgmii_chr[k] = (blk.ctl.chr[k] == PCS_IDLE) ? CGMII_IDLE : CGMII_ERROR;
            if ((k > t_pos) && !char_ok[k])
                trail_ok = 1'b0;
        end
    end

    // data bytes of a T block start one byte after the type
    assign t_data = {blk.lane[1:7], 8'h00};

    assign ocode   = blk.lane[4][7:4];
    assign os_zero = (blk[27:0] == 28'h0);

    assign type_d    = data_sh;
    assign type_s    = ctrl_sh && (blk.ctl.btype == BTYPE_S);
    assign type_idle = ctrl_sh && (blk.ctl.btype == BTYPE_CTRL) &&
                       (blk.ctl.chr == {8{PCS_IDLE}});
    assign type_q    = ctrl_sh && (blk.ctl.btype == BTYPE_ORDER) && (ocode == 4'h0) && os_zero;
    assign type_fsig = ctrl_sh && (blk.ctl.btype == BTYPE_ORDER) && (ocode == 4'hF) && os_zero;
    assign type_c    = type_idle || type_q || type_fsig;
    assign type_term = ctrl_sh && is_t && trail_ok;

    assign o_r_type = {type_d, type_s, type_c, type_term};
    assign o_valid  = valid_q;

    // cgmii word, lane 0 in the top byte
    always_comb
    begin
        o_rx_data = EBLOCK_DATA;
        o_rx_ctrl = EBLOCK_CTRL;
        if (type_d)
        begin
            o_rx_data = blk.lane;
            o_rx_ctrl = 8'h00;
        end
        else if (type_s)
        begin
            o_rx_data = {CGMII_START, blk.lane[1:7]};
            o_rx_ctrl = 8'h80;
        end
        else if (type_idle)
        begin
            o_rx_data = {8{CGMII_IDLE}};
            o_rx_ctrl = 8'hFF;
        end
        else if (type_q || type_fsig)
        begin
            o_rx_data = {type_q ? CGMII_Q : CGMII_FSIG, blk.lane[1:3], 32'h0};
            o_rx_ctrl = 8'h80;
        end
        else if (type_term)
        begin
            for (int k = 0; k < 8; k++)
            begin
                if (k < t_pos)
                    o_rx_data[63-8*k -: 8] = t_data[k];
                else if (k == t_pos)
                    o_rx_data[63-8*k -: 8] = CGMII_TERMINATE;
                else
                    o_rx_data[63-8*k -: 8] = cgmii_chr[k];
            end
            o_rx_ctrl = 8'hFF >> t_pos; // T0 FF down to T7 01
        end
    end

    // a valid block is never classed as two types at once
    a_rtype_onehot : assert property (@(posedge i_clock) disable iff (i_reset)
        o_valid |-> $onehot0(o_r_type));

endmodule

//--- pcs_rx.f
pcs_rx_pkg.sv
decoder_comparator.sv
rx_sequence_fsm.sv
pcs_rx_regs.sv
pcs_rx_top.sv
tb_pcs_rx.sv

//--- pcs_rx_pkg.sv
package pcs_rx_pkg;

    // fixed by the 64b/66b coding
    localparam int LEN_CODED_BLOCK = 66;
    localparam int LEN_RX_DATA     = 64;
    localparam int LEN_RX_CTRL     = 8;
    localparam int LEN_PCS_CHAR    = 7;

    localparam logic [1:0] DATA_SH = 2'b01;
    localparam logic [1:0] CTRL_SH = 2'b10;

    // block type field
    localparam logic [7:0] BTYPE_CTRL  = 8'h1E;
    localparam logic [7:0] BTYPE_S     = 8'h78;
    localparam logic [7:0] BTYPE_ORDER = 8'h4B;
    localparam logic [7:0] BTYPE_T0    = 8'h87;
    localparam logic [7:0] BTYPE_T1    = 8'h99;
    localparam logic [7:0] BTYPE_T2    = 8'hAA;
    localparam logic [7:0] BTYPE_T3    = 8'hB4;
    localparam logic [7:0] BTYPE_T4    = 8'hCC;
    localparam logic [7:0] BTYPE_T5    = 8'hD2;
    localparam logic [7:0] BTYPE_T6    = 8'hE1;
    localparam logic [7:0] BTYPE_T7    = 8'hFF;

    localparam logic [7:0] CGMII_IDLE      = 8'h07;
    localparam logic [7:0] CGMII_START     = 8'hFB;
    localparam logic [7:0] CGMII_TERMINATE = 8'hFD;
    localparam logic [7:0] CGMII_ERROR     = 8'hFE;
    localparam logic [7:0] CGMII_Q         = 8'h9C;
    localparam logic [7:0] CGMII_FSIG      = 8'h5C;

    localparam logic [LEN_PCS_CHAR-1:0] PCS_IDLE  = 7'h00;
    localparam logic [LEN_PCS_CHAR-1:0] PCS_ERROR = 7'h1E;

    // one-hot, order D S C T
    localparam logic [3:0] R_TYPE_D = 4'b1000;
    localparam logic [3:0] R_TYPE_S = 4'b0100;
    localparam logic [3:0] R_TYPE_C = 4'b0010;
    localparam logic [3:0] R_TYPE_T = 4'b0001;
    localparam logic [3:0] R_TYPE_E = 4'b0000; // invalid block

    // local fault ordered set, lane 0 on top
    localparam logic [LEN_RX_DATA-1:0] LBLOCK_DATA = 64'h9C00_0001_0000_0000;
    localparam logic [LEN_RX_CTRL-1:0] LBLOCK_CTRL = 8'h80;
    localparam logic [LEN_RX_DATA-1:0] EBLOCK_DATA = {8{CGMII_ERROR}};
    localparam logic [LEN_RX_CTRL-1:0] EBLOCK_CTRL = 8'hFF;

    // wishbone word addresses
    localparam int              WB_ADR_W        = 2;
    localparam logic [WB_ADR_W-1:0] REG_CTRL        = 2'd0;
    localparam logic [WB_ADR_W-1:0] REG_STATUS      = 2'd1;
    localparam logic [WB_ADR_W-1:0] REG_ERR_COUNT   = 2'd2;
    localparam logic [WB_ADR_W-1:0] REG_FRAME_COUNT = 2'd3;
    localparam int              CNT_W           = 16;

    typedef enum logic [2:0] {
        SEQ_INIT  = 3'd0,
        SEQ_IDLE  = 3'd1,
        SEQ_FRAME = 3'd2,
        SEQ_ERROR = 3'd3
    } seq_state_t;

    // the 64 bits after the sync header, read as data or as control
    typedef union packed {
        logic [0:7][7:0] lane;
        struct packed {
            logic [7:0]                   btype;
            logic [0:7][LEN_PCS_CHAR-1:0] chr; // char 0 on top
        } ctl;
    } rx_block_u;

endpackage

//--- pcs_rx_regs.sv
`timescale 1ns/1ns

module pcs_rx_regs
(
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  logic                            i_wb_cyc,
    input  logic                            i_wb_stb,
    input  logic                            i_wb_we,
    input  logic [pcs_rx_pkg::WB_ADR_W-1:0] i_wb_adr,
    input  logic [31:0]                     i_wb_dat,
    input  pcs_rx_pkg::seq_state_t          i_state,
    input  logic                            i_block_lock,
    input  logic                            i_err_event,
    input  logic                            i_frame_event,
    output logic [31:0]                     o_wb_dat,
    output logic                            o_wb_ack,
    output logic                            o_rx_enable
);
    import pcs_rx_pkg::*;

    logic             req;     // new request, not yet acked
    logic             wr;
    logic [CNT_W-1:0] err_count;
    logic [CNT_W-1:0] frame_count;
    logic [31:0]      rd_data;

    assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign wr  = req && i_wb_we;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_wb_ack <= 1'b0;
        else
            o_wb_ack <= req; // single cycle, master drops stb after it
    end

    // control register
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_rx_enable <= 1'b0;
        else if (wr && (i_wb_adr == REG_CTRL))
            o_rx_enable <= i_wb_dat[0];
    end

    // saturating counters, a write clears
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            err_count <= '0;
        else if (wr && (i_wb_adr == REG_ERR_COUNT))
            err_count <= '0;
        else if (i_err_event && (err_count != {CNT_W{1'b1}}))
            err_count <= err_count + 1'b1;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            frame_count <= '0;
        else if (wr && (i_wb_adr == REG_FRAME_COUNT))
            frame_count <= '0;
        else if (i_frame_event && (frame_count != {CNT_W{1'b1}}))
            frame_count <= frame_count + 1'b1;
    end

    // read mux
    always_comb
    begin
        rd_data = 32'h0;
        case (i_wb_adr)
            REG_CTRL:        rd_data[0]       = o_rx_enable;
            REG_STATUS:
            begin
                rd_data[2:0] = i_state;
                rd_data[4]   = i_block_lock;
            end
            REG_ERR_COUNT:   rd_data[CNT_W-1:0] = err_count;
            REG_FRAME_COUNT: rd_data[CNT_W-1:0] = frame_count;
            default:         rd_data = 32'h0;
        endcase
    end

    // held for the ack cycle
    always_ff @(posedge i_clock)
    begin
        if (req)
            o_wb_dat <= rd_data;
    end

    a_ack_after_req : assert property (@(posedge i_clock) disable iff (i_reset)
        o_wb_ack |-> $past(i_wb_cyc && i_wb_stb));

endmodule

//--- pcs_rx_top.sv
`timescale 1ns/1ns

module pcs_rx_top
(
    input  logic                                   i_clock,
    input  logic                                   i_reset,
    input  logic [pcs_rx_pkg::LEN_CODED_BLOCK-1:0] i_rx_coded,
    input  logic                                   i_rx_valid,
    input  logic                                   i_block_lock,
    input  logic                                   i_wb_cyc,
    input  logic                                   i_wb_stb,
    input  logic                                   i_wb_we,
    input  logic [pcs_rx_pkg::WB_ADR_W-1:0]        i_wb_adr,
    input  logic [31:0]                            i_wb_dat,
    output logic [pcs_rx_pkg::LEN_RX_DATA-1:0]     o_rx_data,
    output logic [pcs_rx_pkg::LEN_RX_CTRL-1:0]     o_rx_ctrl,
    output logic                                   o_rx_valid,
    output logic [31:0]                            o_wb_dat,
    output logic                                   o_wb_ack
);
    import pcs_rx_pkg::*;

    logic [LEN_RX_DATA-1:0] dec_data;
    logic [LEN_RX_CTRL-1:0] dec_ctrl;
    logic [3:0]             dec_r_type;
    logic                   dec_valid;
    seq_state_t             seq_state;
    logic                   err_event;
    logic                   frame_event;
    logic                   rx_enable;

    decoder_comparator u_decoder (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_enable   (i_rx_valid),
        .i_rx_coded (i_rx_coded),
        .o_rx_data  (dec_data),
        .o_rx_ctrl  (dec_ctrl),
        .o_r_type   (dec_r_type),
        .o_valid    (dec_valid)
    );

    rx_sequence_fsm u_sequencer (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (dec_valid),
        .i_data        (dec_data),
        .i_ctrl        (dec_ctrl),
        .i_r_type      (dec_r_type),
        .i_block_lock  (i_block_lock),
        .i_rx_enable   (rx_enable),
        .o_rx_data     (o_rx_data),
        .o_rx_ctrl     (o_rx_ctrl),
        .o_rx_valid    (o_rx_valid),
        .o_state       (seq_state),
        .o_err_event   (err_event),
        .o_frame_event (frame_event)
    );

    pcs_rx_regs u_regs (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_wb_cyc      (i_wb_cyc),
        .i_wb_stb      (i_wb_stb),
        .i_wb_we       (i_wb_we),
        .i_wb_adr      (i_wb_adr),
        .i_wb_dat      (i_wb_dat),
        .i_state       (seq_state),
        .i_block_lock  (i_block_lock),
        .i_err_event   (err_event),
        .i_frame_event (frame_event),
        .o_wb_dat      (o_wb_dat),
        .o_wb_ack      (o_wb_ack),
        .o_rx_enable   (rx_enable)
    );

endmodule

//--- rx_sequence_fsm.sv
`timescale 1ns/1ns

module rx_sequence_fsm
(
    input  logic                               i_clock,
    input  logic                               i_reset,
    input  logic                               i_valid,
    input  logic [pcs_rx_pkg::LEN_RX_DATA-1:0] i_data,
    input  logic [pcs_rx_pkg::LEN_RX_CTRL-1:0] i_ctrl,
    input  logic [3:0]                         i_r_type,
    input  logic                               i_block_lock,
    input  logic                               i_rx_enable,
    output logic [pcs_rx_pkg::LEN_RX_DATA-1:0] o_rx_data,
    output logic [pcs_rx_pkg::LEN_RX_CTRL-1:0] o_rx_ctrl,
    output logic                               o_rx_valid,
    output pcs_rx_pkg::seq_state_t             o_state,
    output logic                               o_err_event,
    output logic                               o_frame_event
);
    import pcs_rx_pkg::*;

    seq_state_t state;
    seq_state_t next_state;
    logic       run;      // lock and enable both up
    logic       replace;  // block breaks frame order
    logic       frame_end;

    assign run = i_block_lock && i_rx_enable;

    always_comb
    begin
        next_state = state;
        replace    = 1'b0;
        frame_end  = 1'b0;
        case (state)
            SEQ_INIT, SEQ_IDLE:
            begin
                if (i_r_type == R_TYPE_C)
                    next_state = SEQ_IDLE;
                else if (i_r_type == R_TYPE_S)
                    next_state = SEQ_FRAME;
                else
                begin
                    replace    = 1'b1;
                    next_state = SEQ_ERROR;
                end
            end
            SEQ_FRAME:
            begin
                if (i_r_type == R_TYPE_T)
                begin
                    frame_end  = 1'b1;
                    next_state = SEQ_IDLE;
                end
                else if (i_r_type != R_TYPE_D)
                begin
                    replace    = 1'b1;
                    next_state = SEQ_ERROR;
                end
            end
            SEQ_ERROR:
            begin
                if ((i_r_type == R_TYPE_C) || (i_r_type == R_TYPE_T))
                    next_state = SEQ_IDLE;
                else if ((i_r_type == R_TYPE_S) || (i_r_type == R_TYPE_D))
                    next_state = SEQ_FRAME;
                else
                    replace = (i_r_type == R_TYPE_E);
            end
            default:
                next_state = SEQ_INIT;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state         <= SEQ_INIT;
            o_rx_valid    <= 1'b0;
            o_err_event   <= 1'b0;
            o_frame_event <= 1'b0;
        end
        else
        begin
            o_rx_valid    <= i_valid;
            o_err_event   <= i_valid && run && replace;
            o_frame_event <= i_valid && run && frame_end;
            if (!run)
                state <= SEQ_INIT; // held here until lock and enable return
            else if (i_valid)
                state <= next_state;
        end
    end

    // output block register
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            if (!run)
            begin
                o_rx_data <= LBLOCK_DATA;
                o_rx_ctrl <= LBLOCK_CTRL;
            end
            else if (replace)
            begin
                o_rx_data <= EBLOCK_DATA;
                o_rx_ctrl <= EBLOCK_CTRL;
            end
            else
            begin
                o_rx_data <= i_data;
                o_rx_ctrl <= i_ctrl;
            end
        end
    end

    assign o_state = state;

    a_events_excl : assert property (@(posedge i_clock) disable iff (i_reset)
        !(o_err_event && o_frame_event));

    a_valid_follows : assert property (@(posedge i_clock) disable iff (i_reset)
        o_rx_valid == $past(i_valid));

endmodule

//--- tb_pcs_rx.sv
`timescale 1ns/1ns

module tb_pcs_rx;
    import pcs_rx_pkg::*;

    localparam int WAIT_LIMIT = 40; // cycles allowed per wait loop

    logic                       i_clock;
    logic                       i_reset;
    logic [LEN_CODED_BLOCK-1:0] i_rx_coded;
    logic                       i_rx_valid;
    logic                       i_block_lock;
    logic                       i_wb_cyc;
    logic                       i_wb_stb;
    logic                       i_wb_we;
    logic [WB_ADR_W-1:0]        i_wb_adr;
    logic [31:0]                i_wb_dat;
    logic [LEN_RX_DATA-1:0]     o_rx_data;
    logic [LEN_RX_CTRL-1:0]     o_rx_ctrl;
    logic                       o_rx_valid;
    logic [31:0]                o_wb_dat;
    logic                       o_wb_ack;

    logic [LEN_RX_DATA-1:0] exp_data_q[$]; // expected cgmii words in order
    logic [LEN_RX_CTRL-1:0] exp_ctrl_q[$];
    logic [31:0]            rng;

    pcs_rx_top DUT (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_rx_coded   (i_rx_coded),
        .i_rx_valid   (i_rx_valid),
        .i_block_lock (i_block_lock),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_adr     (i_wb_adr),
        .i_wb_dat     (i_wb_dat),
        .o_rx_data    (o_rx_data),
        .o_rx_ctrl    (o_rx_ctrl),
        .o_rx_valid   (o_rx_valid),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    task automatic fail_and_stop();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        fail_and_stop();
    endtask

    task automatic check_block(input logic [LEN_RX_DATA-1:0] exp_data,
                               input logic [LEN_RX_CTRL-1:0] exp_ctrl,
                               input logic [LEN_RX_DATA-1:0] got_data,
                               input logic [LEN_RX_CTRL-1:0] got_ctrl);
        if (got_data !== exp_data)
        begin
            $display("** Error: o_rx_data expected %h got %h", exp_data, got_data);
            fail_and_stop();
        end
        if (got_ctrl !== exp_ctrl)
        begin
            $display("** Error: o_rx_ctrl expected %h got %h", exp_ctrl, got_ctrl);
            fail_and_stop();
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp)
        begin
            $display("** Error: %s expected %h got %h", name, exp, got);
            fail_and_stop();
        end
    endtask

    task automatic check_state(input string name, input seq_state_t exp, input seq_state_t got);
        if (got !== exp)
        begin
            $display("** Error: %s expected %h got %h", name, exp, got);
            fail_and_stop();
        end
    endtask

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [63:0] random64();
        logic [31:0] hi;
        hi = next_random();
        return {hi, next_random()};
    endfunction

    function automatic logic [7:0] term_type(input int k);
        case (k)
            0:       term_type = BTYPE_T0;
            1:       term_type = BTYPE_T1;
            2:       term_type = BTYPE_T2;
            3:       term_type = BTYPE_T3;
            4:       term_type = BTYPE_T4;
            5:       term_type = BTYPE_T5;
            6:       term_type = BTYPE_T6;
            default: term_type = BTYPE_T7;
        endcase
    endfunction

    function automatic logic [LEN_CODED_BLOCK-1:0] encode_idle();
        rx_block_u b;
        b.ctl.btype = BTYPE_CTRL;
        for (int j = 0; j < 8; j++)
            b.ctl.chr[j] = PCS_IDLE;
        return {CTRL_SH, b};
    endfunction

    // q or fsig ordered set with three data bytes then the O code
    function automatic logic [LEN_CODED_BLOCK-1:0] encode_oset(input logic [3:0] ocode,
                                                               input logic [23:0] s);
        rx_block_u b;
        b = '0;
        b.ctl.btype = BTYPE_ORDER;
        b.lane[1]   = s[23:16];
        b.lane[2]   = s[15:8];
        b.lane[3]   = s[7:0];
        b.lane[4]   = {ocode, 4'h0};
        return {CTRL_SH, b};
    endfunction

    function automatic logic [LEN_CODED_BLOCK-1:0] encode_start(input logic [63:0] d);
        rx_block_u b;
        b.lane      = d;
        b.ctl.btype = BTYPE_S; // lane 0 carries the type and becomes /S/ on the cgmii side
        return {CTRL_SH, b};
    endfunction

    // k data bytes from the top of d and a selectable last trailing char
    function automatic logic [LEN_CODED_BLOCK-1:0] encode_term(input int k, input logic [63:0] d,
                                                               input logic [6:0] last_chr);
        rx_block_u b;
        b = '0;
        b.ctl.chr[7] = last_chr;
        b.ctl.btype  = term_type(k);
        for (int j = 0; j < k; j++)
            b.lane[j+1] = d[63-8*j -: 8];
        return {CTRL_SH, b};
    endfunction

    task automatic send_block(input logic [LEN_CODED_BLOCK-1:0] coded,
                              input logic [LEN_RX_DATA-1:0] exp_data,
                              input logic [LEN_RX_CTRL-1:0] exp_ctrl);
        @(posedge i_clock);
        i_rx_valid <= 1'b1;
        i_rx_coded <= coded;
        exp_data_q.push_back(exp_data);
        exp_ctrl_q.push_back(exp_ctrl);
    endtask

    task automatic send_term(input int k, input logic [63:0] d);
        logic [63:0] exp_d;
        logic [7:0]  exp_c;
        for (int j = 0; j < 8; j++)
        begin
            if (j < k)
                exp_d[63-8*j -: 8] = d[63-8*j -: 8];
            else if (j == k)
                exp_d[63-8*j -: 8] = CGMII_TERMINATE;
            else
                exp_d[63-8*j -: 8] = CGMII_IDLE;
            exp_c[7-j] = (j >= k); // control from the /T/ lane on
        end
        send_block(encode_term(k, d, PCS_IDLE), exp_d, exp_c);
    endtask

    // stop the stream and wait until every expected block came out
    task automatic drain();
        int n;
        @(posedge i_clock);
        i_rx_valid <= 1'b0;
        n = 0;
        while (exp_data_q.size() != 0)
        begin
            if (n == WAIT_LIMIT)
                timed_out("the expected output blocks");
            n++;
            @(negedge i_clock);
        end
    endtask

    always @(negedge i_clock)
    begin
        if (!i_reset && o_rx_valid)
        begin
            if (exp_data_q.size() == 0)
            begin
                $display("output block appeared with nothing expected");
                fail_and_stop();
            end
            else
                check_block(exp_data_q.pop_front(), exp_ctrl_q.pop_front(), o_rx_data, o_rx_ctrl);
        end
    end

    task automatic wait_ack(input string what);
        int n;
        n = 0;
        @(negedge i_clock);
        while (o_wb_ack !== 1'b1)
        begin
            if (n == WAIT_LIMIT)
                timed_out(what);
            n++;
            @(negedge i_clock);
        end
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [31:0] dat);
        @(posedge i_clock);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= 1'b1;
        i_wb_adr <= adr;
        i_wb_dat <= dat;
        wait_ack("wishbone ack on a write");
        @(posedge i_clock);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [31:0] dat);
        @(posedge i_clock);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= 1'b0;
        i_wb_adr <= adr;
        wait_ack("wishbone ack on a read");
        dat = o_wb_dat; // valid while ack is high
        @(posedge i_clock);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
    endtask

    task automatic expect_reg(input logic [WB_ADR_W-1:0] adr, input string name,
                              input logic [31:0] exp);
        logic [31:0] rd;
        wb_read(adr, rd);
        check_reg(name, exp, rd);
    endtask

    task automatic expect_status(input seq_state_t exp_state, input logic exp_lock);
        logic [31:0] rd;
        wb_read(REG_STATUS, rd);
        check_state("status state", exp_state, seq_state_t'(rd[2:0]));
        check_reg("status lock", {31'h0, exp_lock}, {31'h0, rd[4]});
    endtask

    task automatic test_local_fault();
        send_block(encode_idle(), LBLOCK_DATA, LBLOCK_CTRL);
        send_block({DATA_SH, random64()}, LBLOCK_DATA, LBLOCK_CTRL);
        send_block(encode_start(random64()), LBLOCK_DATA, LBLOCK_CTRL);
        drain();
        expect_status(SEQ_INIT, 1'b1);
    endtask

    task automatic test_decode();
        logic [63:0] d;
        wb_write(REG_CTRL, 32'h1);
        send_block(encode_idle(), {8{CGMII_IDLE}}, 8'hFF);
        send_block(encode_oset(4'h0, 24'h000001), {CGMII_Q, 24'h000001, 32'h0}, 8'h80);
        send_block(encode_oset(4'hF, 24'h123456), {CGMII_FSIG, 24'h123456, 32'h0}, 8'h80);
        for (int k = 0; k < 8; k++)
        begin
            d = random64();
            send_block(encode_start(d), {CGMII_START, d[55:0]}, 8'h80);
            d = random64();
            send_block({DATA_SH, d}, d, 8'h00);
            d = random64();
            send_block({DATA_SH, d}, d, 8'h00);
            send_term(k, random64());
        end
        send_block(encode_idle(), {8{CGMII_IDLE}}, 8'hFF);
        drain();
        expect_reg(REG_FRAME_COUNT, "frame count", 32'd8);
        expect_reg(REG_ERR_COUNT, "error count", 32'd0);
        expect_status(SEQ_IDLE, 1'b1);
    endtask

    task automatic test_order_errors();
        logic [63:0] d;
        d = random64();
        send_block({DATA_SH, d}, EBLOCK_DATA, EBLOCK_CTRL);  // data outside a frame
        send_block(encode_idle(), {8{CGMII_IDLE}}, 8'hFF);
        d = random64();
        send_block(encode_start(d), {CGMII_START, d[55:0]}, 8'h80);
        send_block(encode_start(random64()), EBLOCK_DATA, EBLOCK_CTRL);
        d = random64();
        send_block({DATA_SH, d}, d, 8'h00); // reopens the frame from ERROR
        send_term(4, random64());
        drain();
        expect_reg(REG_ERR_COUNT, "error count", 32'd2);
        expect_reg(REG_FRAME_COUNT, "frame count", 32'd9);
        expect_status(SEQ_IDLE, 1'b1);
    endtask

    task automatic test_invalid_blocks();
        send_block({2'b00, random64()}, EBLOCK_DATA, EBLOCK_CTRL);
        send_block({2'b11, random64()}, EBLOCK_DATA, EBLOCK_CTRL);
        send_block({CTRL_SH, 8'h55, 56'h0}, EBLOCK_DATA, EBLOCK_CTRL); // unknown type
        send_block(encode_term(3, random64(), 7'h2A), EBLOCK_DATA, EBLOCK_CTRL);
        drain();
        expect_reg(REG_ERR_COUNT, "error count", 32'd6);
        expect_status(SEQ_ERROR, 1'b1);
        send_block(encode_idle(), {8{CGMII_IDLE}}, 8'hFF);
        drain();
        expect_status(SEQ_IDLE, 1'b1);
    endtask

    task automatic test_counter_clear();
        wb_write(REG_ERR_COUNT, 32'hFFFF_FFFF);
        expect_reg(REG_ERR_COUNT, "error count", 32'd0);
        expect_reg(REG_FRAME_COUNT, "frame count", 32'd9);
        send_block({DATA_SH, random64()}, EBLOCK_DATA, EBLOCK_CTRL); // one fresh error
        send_block(encode_idle(), {8{CGMII_IDLE}}, 8'hFF);
        drain();
        wb_write(REG_FRAME_COUNT, 32'h0);
        expect_reg(REG_FRAME_COUNT, "frame count", 32'd0);
        expect_reg(REG_ERR_COUNT, "error count", 32'd1);
        wb_write(REG_CTRL, 32'h0);
        expect_reg(REG_CTRL, "ctrl", 32'h0);
        send_block(encode_idle(), LBLOCK_DATA, LBLOCK_CTRL);
        drain();
        expect_status(SEQ_INIT, 1'b1);
        wb_write(REG_CTRL, 32'h1);
        expect_reg(REG_CTRL, "ctrl", 32'h1);
    endtask

    task automatic test_lock_loss();
        logic [63:0] d;
        send_block(encode_idle(), {8{CGMII_IDLE}}, 8'hFF);
        d = random64();
        send_block(encode_start(d), {CGMII_START, d[55:0]}, 8'h80);
        d = random64();
        send_block({DATA_SH, d}, d, 8'h00);
        drain();
        @(posedge i_clock);
        i_block_lock <= 1'b0; // lost in the middle of the frame
        send_block({DATA_SH, random64()}, LBLOCK_DATA, LBLOCK_CTRL);
        drain();
        expect_status(SEQ_INIT, 1'b0);
        @(posedge i_clock);
        i_block_lock <= 1'b1;
        send_block(encode_idle(), {8{CGMII_IDLE}}, 8'hFF);
        d = random64();
        send_block(encode_start(d), {CGMII_START, d[55:0]}, 8'h80);
        send_term(7, random64());
        drain();
        expect_reg(REG_FRAME_COUNT, "frame count", 32'd1);
        expect_reg(REG_ERR_COUNT, "error count", 32'd1);
        expect_status(SEQ_IDLE, 1'b1);
    endtask

    initial
    begin
        i_reset      = 1'b1;
        i_rx_coded   = '0;
        i_rx_valid   = 1'b0;
        i_block_lock = 1'b1;
        i_wb_cyc     = 1'b0;
        i_wb_stb     = 1'b0;
        i_wb_we      = 1'b0;
        i_wb_adr     = '0;
        i_wb_dat     = '0;
        rng          = 32'h6cdf;
        repeat (5) @(posedge i_clock);
        i_reset <= 1'b0;

        test_local_fault();
        test_decode();
        test_order_errors();
        test_invalid_blocks();
        test_counter_clear();
        test_lock_loss();

        $display("TESTS PASSED");
        $finish;
    end

endmodule
